// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing -j 0
TOP = tb_cpu
FILELIST = compile.f
SIM = obj_dir/V$(TOP)
PASS_MSG = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: compile.f
hdl/lc3b_types.sv
hdl/reg_write_if.sv
hdl/pipe_latch.sv
hdl/instruction_fetch.sv
hdl/instruction_decode.sv
hdl/execution_module.sv
hdl/memory_module.sv
hdl/writeback_module.sv
hdl/flow_control.sv
hdl/cpu_datapath.sv
tb/clk_gen.sv
tb/tb_cpu.sv

// File: hdl/cpu_datapath.sv
`default_nettype none

module cpu_datapath
	import lc3b_types::*;
#(
	parameter lc3b_word reset_pc = 16'h0000
) (
	input logic clk,
	input logic rst_n,
	output lc3b_word mem_addr1,
	output logic mem_read1,
	input lc3b_word mem_rdata1,
	input logic resp_a,
	output lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	output lc3b_word mem_wdata2,
	output lc3b_mem_wmask mem_byte_enable2,
	input lc3b_word mem_rdata2,
	input logic resp_b
);

	if_id_t fetch_out, if_id_q;
	id_ex_t id_out, id_ex_q;
	ex_mem_t ex_out, ex_mem_q;
	mem_wb_t mem_out, mem_wb_q;
	logic fetch_valid, if_id_valid, id_ex_valid, ex_mem_valid, mem_wb_valid;

	lc3b_reg src1, src2;
	logic uses_src2, is_branch;
	lc3b_nzp cur_cc;
	logic redirect;
	lc3b_word redirect_pc;
	logic mem_busy;

	logic advance, fetch_redirect;
	logic if_id_load, if_id_flush, id_ex_load, id_ex_flush, ex_mem_load, mem_wb_load;

	reg_write_if rw ();

	// ------------------------------
	// Fetch and decode
	// ------------------------------

	instruction_fetch #(
		.reset_pc(reset_pc)
	) u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.resp_a(resp_a),
		.mem_rdata1(mem_rdata1),
		.advance(advance),
		.redirect(fetch_redirect),
		.redirect_pc(redirect_pc),
		.mem_addr1(mem_addr1),
		.mem_read1(mem_read1),
		.fetch_valid(fetch_valid),
		.fetch_out(fetch_out)
	);

	pipe_latch #(.payload_t(if_id_t)) u_if_id (
		.clk(clk),
		.rst_n(rst_n),
		.load(if_id_load),
		.flush(if_id_flush),
		.valid_in(fetch_valid),
		.data_in(fetch_out),
		.valid_out(if_id_valid),
		.data_out(if_id_q)
	);

	instruction_decode u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.if_id(if_id_q),
		.rw(rw.dst),
		.id_out(id_out),
		.src1(src1),
		.src2(src2),
		.uses_src2(uses_src2),
		.is_branch(is_branch),
		.cur_cc(cur_cc)
	);

	pipe_latch #(.payload_t(id_ex_t)) u_id_ex (
		.clk(clk),
		.rst_n(rst_n),
		.load(id_ex_load),
		.flush(id_ex_flush),
		.valid_in(if_id_valid),
		.data_in(id_out),
		.valid_out(id_ex_valid),
		.data_out(id_ex_q)
	);

	// ------------------------------
	// Execute, memory, writeback
	// ------------------------------

	execution_module u_execute (
		.id_ex(id_ex_q),
		.id_ex_valid(id_ex_valid),
		.cur_cc(cur_cc),
		.ex_out(ex_out),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	pipe_latch #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk(clk),
		.rst_n(rst_n),
		.load(ex_mem_load),
		.flush(1'b0),
		.valid_in(id_ex_valid),
		.data_in(ex_out),
		.valid_out(ex_mem_valid),
		.data_out(ex_mem_q)
	);

	memory_module u_memory (
		.clk(clk),
		.rst_n(rst_n),
		.ex_mem(ex_mem_q),
		.ex_mem_valid(ex_mem_valid),
		.advance(mem_wb_load),
		.mem_rdata2(mem_rdata2),
		.resp_b(resp_b),
		.mem_addr2(mem_addr2),
		.mem_read2(mem_read2),
		.mem_write2(mem_write2),
		.mem_wdata2(mem_wdata2),
		.mem_byte_enable2(mem_byte_enable2),
		.mem_busy(mem_busy),
		.mem_out(mem_out)
	);

	pipe_latch #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk(clk),
		.rst_n(rst_n),
		.load(mem_wb_load),
		.flush(1'b0),
		.valid_in(ex_mem_valid),
		.data_in(mem_out),
		.valid_out(mem_wb_valid),
		.data_out(mem_wb_q)
	);

	writeback_module u_writeback (
		.mem_wb(mem_wb_q),
		.mem_wb_valid(mem_wb_valid),
		.rw(rw.src)
	);

	flow_control u_flow_control (
		.src1(src1),
		.src2(src2),
		.uses_src2(uses_src2),
		.is_branch(is_branch),
		.if_id_valid(if_id_valid),
		.fetch_valid(fetch_valid),
		.mem_busy(mem_busy),
		.redirect(redirect),
		.id_ex_dest(id_ex_q.dest),
		.id_ex_regfile_load(id_ex_q.ctrl.regfile_load),
		.id_ex_set_cc(id_ex_q.ctrl.set_cc),
		.id_ex_valid(id_ex_valid),
		.ex_mem_dest(ex_mem_q.dest),
		.ex_mem_regfile_load(ex_mem_q.ctrl.regfile_load),
		.ex_mem_set_cc(ex_mem_q.ctrl.set_cc),
		.ex_mem_valid(ex_mem_valid),
		.mem_wb_set_cc(mem_wb_q.ctrl.set_cc),
		.mem_wb_valid(mem_wb_valid),
		.advance(advance),
		.fetch_redirect(fetch_redirect),
		.if_id_load(if_id_load),
		.if_id_flush(if_id_flush),
		.id_ex_load(id_ex_load),
		.id_ex_flush(id_ex_flush),
		.ex_mem_load(ex_mem_load),
		.mem_wb_load(mem_wb_load)
	);

endmodule : cpu_datapath

`default_nettype wire

// File: hdl/execution_module.sv
`default_nettype none

module execution_module
	import lc3b_types::*;
(
	input id_ex_t id_ex,
	input logic id_ex_valid,
	input lc3b_nzp cur_cc,
	output ex_mem_t ex_out,
	output logic redirect,
	output lc3b_word redirect_pc
);

	lc3b_word operand_b;
	lc3b_word alu_result;
	lc3b_word addr;

	always_comb begin
		operand_b = id_ex.ctrl.imm_sel ? id_ex.imm : id_ex.sr2;
		case (id_ex.ctrl.aluop)
			alu_and: alu_result = id_ex.sr1 & operand_b;
			alu_not: alu_result = ~id_ex.sr1;
			default: alu_result = id_ex.sr1 + operand_b;
		endcase
	end

	// Shared adder for LDR/STR address and branch target
	assign addr = (id_ex.ctrl.offset_sel ? id_ex.pc : id_ex.sr1) + id_ex.imm;

	always_comb begin
		ex_out.ctrl = id_ex.ctrl;
		ex_out.alu = (id_ex.ctrl.mem_read || id_ex.ctrl.mem_write) ? addr : alu_result;
		ex_out.store_data = id_ex.sr2;
		ex_out.dest = id_ex.dest;
	end

	// nzp field of BR against the current condition codes
	assign redirect = id_ex_valid && id_ex.ctrl.is_branch && |(id_ex.ir[11:9] & cur_cc);
	assign redirect_pc = addr;

endmodule : execution_module

`default_nettype wire

// File: hdl/flow_control.sv
`default_nettype none

module flow_control
	import lc3b_types::*;
(
	input lc3b_reg src1,
	input lc3b_reg src2,
	input logic uses_src2,
	input logic is_branch,
	input logic if_id_valid,
	input logic fetch_valid,
	input logic mem_busy,
	input logic redirect,
	input lc3b_reg id_ex_dest,
	input logic id_ex_regfile_load,
	input logic id_ex_set_cc,
	input logic id_ex_valid,
	input lc3b_reg ex_mem_dest,
	input logic ex_mem_regfile_load,
	input logic ex_mem_set_cc,
	input logic ex_mem_valid,
	input logic mem_wb_set_cc,
	input logic mem_wb_valid,
	output logic advance,
	output logic fetch_redirect,
	output logic if_id_load,
	output logic if_id_flush,
	output logic id_ex_load,
	output logic id_ex_flush,
	output logic ex_mem_load,
	output logic mem_wb_load
);

	logic raw_hazard;
	logic cc_hazard;

	// A writer in WB is covered by the register file write-through
	function automatic logic writes(lc3b_reg idx);
		return (id_ex_valid && id_ex_regfile_load && id_ex_dest == idx)
			|| (ex_mem_valid && ex_mem_regfile_load && ex_mem_dest == idx);
	endfunction

	assign raw_hazard = if_id_valid && (writes(src1) || (uses_src2 && writes(src2)));
	assign cc_hazard = if_id_valid && is_branch
		&& ((id_ex_valid && id_ex_set_cc)
		|| (ex_mem_valid && ex_mem_set_cc)
		|| (mem_wb_valid && mem_wb_set_cc));

	always_comb begin
		advance = 1'b0;
		fetch_redirect = 1'b0;
		if_id_load = 1'b0;
		if_id_flush = 1'b0;
		id_ex_load = 1'b0;
		id_ex_flush = 1'b0;
		ex_mem_load = 1'b0;
		mem_wb_load = 1'b0;
		if (mem_busy) begin
			// Whole pipe freezes
		end else if (redirect) begin
			fetch_redirect = 1'b1;
			if_id_flush = 1'b1;
			id_ex_flush = 1'b1;
			ex_mem_load = 1'b1;
			mem_wb_load = 1'b1;
		end else if (raw_hazard || cc_hazard) begin
			id_ex_flush = 1'b1;
			ex_mem_load = 1'b1;
			mem_wb_load = 1'b1;
		end else begin
			advance = fetch_valid;
			if_id_load = 1'b1;
			id_ex_load = 1'b1;
			ex_mem_load = 1'b1;
			mem_wb_load = 1'b1;
		end
	end

endmodule : flow_control

`default_nettype wire

// File: hdl/instruction_decode.sv
`default_nettype none

module instruction_decode
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input if_id_t if_id,
	reg_write_if.dst rw,
	output id_ex_t id_out,
	output lc3b_reg src1,
	output lc3b_reg src2,
	output logic uses_src2,
	output logic is_branch,
	output lc3b_nzp cur_cc
);

	lc3b_word regs [8];
	lc3b_nzp cc;
	lc3b_opcode opcode;
	lc3b_control ctrl;
	lc3b_word imm;

	// Write-through so a value retiring this cycle is seen by decode
	function automatic lc3b_word read_reg(lc3b_reg idx);
		if (rw.load && rw.dest == idx) begin
			return rw.data;
		end
		return regs[idx];
	endfunction

	// ------------------------------
	// Register file and CC
	// ------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
			cc <= 3'b010;
		end else begin
			if (rw.load) begin
				regs[rw.dest] <= rw.data;
			end
			if (rw.set_cc) begin
				cc <= rw.nzp;
			end
		end
	end

	assign cur_cc = cc;

	// ------------------------------
	// Control word
	// ------------------------------

	assign opcode = lc3b_opcode'(if_id.ir[15:12]);

	always_comb begin
		ctrl = '0;
		imm = {{11{if_id.ir[4]}}, if_id.ir[4:0]};
		case (opcode)
			op_add, op_and: begin
				ctrl.aluop = (opcode == op_and) ? alu_and : alu_add;
				ctrl.imm_sel = if_id.ir[5];
				ctrl.regfile_load = 1'b1;
				ctrl.set_cc = 1'b1;
			end
			op_not: begin
				ctrl.aluop = alu_not;
				ctrl.regfile_load = 1'b1;
				ctrl.set_cc = 1'b1;
			end
			op_ldr, op_str: begin
				imm = {{9{if_id.ir[5]}}, if_id.ir[5:0], 1'b0};
				ctrl.mem_read = (opcode == op_ldr);
				ctrl.mem_write = (opcode == op_str);
				ctrl.regfile_load = (opcode == op_ldr);
				ctrl.set_cc = (opcode == op_ldr);
			end
			op_br: begin
				imm = {{6{if_id.ir[8]}}, if_id.ir[8:0], 1'b0};
				ctrl.offset_sel = 1'b1;
				ctrl.is_branch = 1'b1;
			end
			default: ;
		endcase
	end

	// STR reads its source from the dest field
	assign src1 = if_id.ir[8:6];
	assign src2 = (opcode == op_str) ? if_id.ir[11:9] : if_id.ir[2:0];
	assign uses_src2 = ((opcode == op_add || opcode == op_and) && !if_id.ir[5])
		|| (opcode == op_str);
	assign is_branch = ctrl.is_branch;

	always_comb begin
		id_out.ir = if_id.ir;
		id_out.pc = if_id.pc;
		id_out.ctrl = ctrl;
		id_out.sr1 = read_reg(src1);
		id_out.sr2 = read_reg(src2);
		id_out.imm = imm;
		id_out.dest = if_id.ir[11:9];
	end

endmodule : instruction_decode

`default_nettype wire

// File: hdl/instruction_fetch.sv
`default_nettype none

module instruction_fetch
	import lc3b_types::*;
#(
	parameter lc3b_word reset_pc = 16'h0000
) (
	input logic clk,
	input logic rst_n,
	input logic resp_a,
	input lc3b_word mem_rdata1,
	input logic advance,
	input logic redirect,
	input lc3b_word redirect_pc,
	output lc3b_word mem_addr1,
	output logic mem_read1,
	output logic fetch_valid,
	output if_id_t fetch_out
);

	lc3b_word pc;
	lc3b_word held_ir;
	lc3b_word pending_pc;
	logic held;
	logic pending;

	assign mem_addr1 = pc;
	// Request stays up until an instruction is sitting in the buffer
	assign mem_read1 = !held;

	assign fetch_valid = !pending && (held || resp_a);
	assign fetch_out.ir = held ? held_ir : mem_rdata1;
	assign fetch_out.pc = pc + 16'd2;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= reset_pc;
			held <= 1'b0;
			pending <= 1'b0;
		end else if (pending) begin
			// Response for the old path is thrown away
			if (resp_a) begin
				pc <= pending_pc;
				pending <= 1'b0;
			end
		end else if (redirect) begin
			if (mem_read1 && !resp_a) begin
				pending <= 1'b1;
				pending_pc <= redirect_pc;
			end else begin
				pc <= redirect_pc;
				held <= 1'b0;
			end
		end else if (advance) begin
			pc <= pc + 16'd2;
			held <= 1'b0;
		end else if (resp_a) begin
			held <= 1'b1;
			held_ir <= mem_rdata1;
		end
	end

endmodule : instruction_fetch

`default_nettype wire

// File: hdl/lc3b_types.sv
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;
	typedef logic [1:0] lc3b_mem_wmask;

	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not
	} lc3b_aluop;

	typedef struct packed {
		lc3b_aluop aluop;
		logic imm_sel;
		// 0 adds to the base register, 1 adds to the PC
		logic offset_sel;
		logic mem_read;
		logic mem_write;
		logic regfile_load;
		logic set_cc;
		logic is_branch;
	} lc3b_control;

	// ------------------------------
	// Stage payloads
	// ------------------------------

	typedef struct packed {
		lc3b_word ir;
		lc3b_word pc;
	} if_id_t;

	typedef struct packed {
		lc3b_word ir;
		lc3b_word pc;
		lc3b_control ctrl;
		lc3b_word sr1;
		lc3b_word sr2;
		// Sign extended imm5, or offset already shifted for address and branch
		lc3b_word imm;
		lc3b_reg dest;
	} id_ex_t;

	typedef struct packed {
		lc3b_control ctrl;
		lc3b_word alu;
		lc3b_word store_data;
		lc3b_reg dest;
	} ex_mem_t;

	typedef struct packed {
		lc3b_control ctrl;
		lc3b_word alu;
		lc3b_word mdr;
		lc3b_reg dest;
	} mem_wb_t;

endpackage : lc3b_types

`default_nettype wire

// File: hdl/memory_module.sv
`default_nettype none

module memory_module
	import lc3b_types::*;
(
	input logic clk,
	input logic rst_n,
	input ex_mem_t ex_mem,
	input logic ex_mem_valid,
	input logic advance,
	input lc3b_word mem_rdata2,
	input logic resp_b,
	output lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	output lc3b_word mem_wdata2,
	output lc3b_mem_wmask mem_byte_enable2,
	output logic mem_busy,
	output mem_wb_t mem_out
);

	logic req;

	assign req = ex_mem_valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);

	assign mem_addr2 = ex_mem.alu;
	assign mem_read2 = req && ex_mem.ctrl.mem_read;
	assign mem_write2 = req && ex_mem.ctrl.mem_write;
	assign mem_wdata2 = ex_mem.store_data;
	assign mem_byte_enable2 = mem_write2 ? 2'b11 : 2'b00;
	assign mem_busy = req && !resp_b;

	// Load data goes straight through since the entry leaves MEM in the resp cycle
	always_comb begin
		mem_out.ctrl = ex_mem.ctrl;
		mem_out.alu = ex_mem.alu;
		mem_out.mdr = mem_rdata2;
		mem_out.dest = ex_mem.dest;
	end

endmodule : memory_module

`default_nettype wire

// File: hdl/pipe_latch.sv
`default_nettype none

module pipe_latch #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic flush,
	input logic valid_in,
	input payload_t data_in,
	output logic valid_out,
	output payload_t data_out
);

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			valid_out <= 1'b0;
		end else if (load) begin
			valid_out <= valid_in;
		end
	end

	// Payload only moves on load, a flushed entry keeps stale data
	always_ff @(posedge clk) begin
		if (load && !flush) begin
			data_out <= data_in;
		end
	end

endmodule : pipe_latch

`default_nettype wire

// File: hdl/reg_write_if.sv
`default_nettype none

interface reg_write_if
	import lc3b_types::*;
();

	logic load;
	lc3b_reg dest;
	lc3b_word data;
	logic set_cc;
	lc3b_nzp nzp;

	modport src (output load, dest, data, set_cc, nzp);
	modport dst (input load, dest, data, set_cc, nzp);

endinterface : reg_write_if

`default_nettype wire

// File: hdl/writeback_module.sv
`default_nettype none

module writeback_module
	import lc3b_types::*;
(
	input mem_wb_t mem_wb,
	input logic mem_wb_valid,
	reg_write_if.src rw
);

	lc3b_word result;

	assign result = mem_wb.ctrl.mem_read ? mem_wb.mdr : mem_wb.alu;

	assign rw.load = mem_wb_valid && mem_wb.ctrl.regfile_load;
	assign rw.set_cc = mem_wb_valid && mem_wb.ctrl.set_cc;
	assign rw.dest = mem_wb.dest;
	assign rw.data = result;

	always_comb begin
		if (result[15]) begin
			rw.nzp = 3'b100;
		end else if (result == '0) begin
			rw.nzp = 3'b010;
		end else begin
			rw.nzp = 3'b001;
		end
	end

endmodule : writeback_module

`default_nettype wire

// File: tb/clk_gen.sv
`default_nettype none

module clk_gen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset held over four rising edges
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule : clk_gen

`default_nettype wire

// File: tb/tb_cpu.sv
`default_nettype none

module tb_cpu;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [15:0] reset_pc = 16'h0040;
	localparam logic [15:0] halt_word = 16'h0FFF;
	localparam int max_cycles = 20000;

	logic clk, rst_n;
	logic [15:0] mem_addr1, mem_rdata1, mem_addr2, mem_wdata2, mem_rdata2;
	logic mem_read1, resp_a, mem_read2, mem_write2, resp_b;
	logic [1:0] mem_byte_enable2;

	logic [15:0] imem [512];
	logic [15:0] dmem [logic [15:0]];
	logic [15:0] prog [$];
	logic [15:0] exp_addr [$];
	logic [15:0] exp_data [$];
	int seed = 95;
	int errors = 0;
	int stores_seen = 0;
	int a_wait, b_wait;
	logic a_busy, b_busy;

	clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

	cpu_datapath #(.reset_pc(reset_pc)) u_cpu_datapath (
		.clk(clk), .rst_n(rst_n),
		.mem_addr1(mem_addr1), .mem_read1(mem_read1),
		.mem_rdata1(mem_rdata1), .resp_a(resp_a),
		.mem_addr2(mem_addr2), .mem_read2(mem_read2), .mem_write2(mem_write2),
		.mem_wdata2(mem_wdata2), .mem_byte_enable2(mem_byte_enable2),
		.mem_rdata2(mem_rdata2), .resp_b(resp_b)
	);

	// ------------------------------
	// Encoding and program build
	// ------------------------------

	function automatic logic [15:0] fill_word(logic [15:0] addr);
		return {addr[7:0], addr[15:8]} ^ 16'h3c5a;
	endfunction

	function automatic int pick(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [15:0] alu_word(logic [3:0] op, int dr, int sr1, bit imm_form,
		int low);
		return {op, 3'(dr), 3'(sr1), imm_form, imm_form ? 5'(low) : {2'b00, 3'(low)}};
	endfunction

	function automatic logic [15:0] mem_word(logic [3:0] op, int rd, int base, int off6);
		return {op, 3'(rd), 3'(base), 6'(off6)};
	endfunction

	function automatic logic [15:0] branch_word(logic [2:0] nzp, int off9);
		return {4'b0000, nzp, 9'(off9)};
	endfunction

	function automatic void emit(logic [15:0] w);
		prog.push_back(w);
	endfunction

	function automatic void random_alu();
		int kind;
		bit imm_form;
		kind = pick(3);
		imm_form = 1'(pick(2));
		if (kind == 2) begin
			emit(alu_word(4'b1001, pick(7), pick(8), 1'b1, 31));
		end else begin
			emit(alu_word(kind == 0 ? 4'b0001 : 4'b0101, pick(7), pick(8), imm_form,
				imm_form ? pick(32) : pick(8)));
		end
	endfunction

	// Stores every register relative to R7
	function automatic void store_all(int base_off);
		for (int i = 0; i < 8; i++) begin
			emit(mem_word(4'b0111, i, 7, base_off + i));
		end
	endfunction

	function automatic void build_program();
		int start;
		for (int i = 0; i < 7; i++) begin
			emit(alu_word(4'b0001, i, i, 1'b1, pick(32)));
		end
		emit(alu_word(4'b0101, 7, 7, 1'b1, 0));
		emit(alu_word(4'b0001, 7, 7, 1'b1, 14));
		repeat (40) random_alu();
		store_all(0);
		// Producer followed directly by its consumer
		emit(alu_word(4'b0001, 1, 0, 1'b0, 2));
		emit(alu_word(4'b0001, 3, 1, 1'b0, 1));
		emit(alu_word(4'b0101, 4, 3, 1'b0, 1));
		emit(alu_word(4'b1001, 5, 4, 1'b1, 31));
		emit(mem_word(4'b0111, 5, 7, 8));
		emit(alu_word(4'b0001, 6, 5, 1'b1, 3));
		emit(mem_word(4'b0111, 6, 7, 9));
		// Load back what was just stored
		emit(mem_word(4'b0111, 2, 7, 10));
		emit(mem_word(4'b0110, 0, 7, 10));
		emit(mem_word(4'b0111, 0, 7, 11));
		emit(alu_word(4'b0001, 1, 0, 1'b1, 1));
		emit(mem_word(4'b0111, 1, 7, 12));
		// Every CC value against every nzp mask
		for (int kind = 0; kind < 3; kind++) begin
			for (int nzp = 0; nzp < 8; nzp++) begin
				emit(alu_word(4'b0001, 4, 4, 1'b1, 1));
				emit(alu_word(4'b0101, 6, 6, 1'b1, 0));
				if (kind == 0) begin
					emit(alu_word(4'b0001, 6, 6, 1'b1, 31));
				end else if (kind == 2) begin
					emit(alu_word(4'b0001, 6, 6, 1'b1, 1));
				end
				emit(branch_word(3'(nzp), 1));
				emit(mem_word(4'b0111, 4, 7, 13));
				emit(mem_word(4'b0111, 4, 7, 14));
			end
		end
		for (int i = 0; i < 60; i++) begin
			case (pick(4))
				0, 1: random_alu();
				2: begin
					if (pick(2) == 0) begin
						emit(mem_word(4'b0110, pick(7), 7, 16 + pick(16)));
					end else begin
						emit(mem_word(4'b0111, pick(8), 7, 16 + pick(16)));
					end
				end
				default: emit(branch_word(3'(pick(8)), 1 + pick(2)));
			endcase
		end
		store_all(-8);
		emit(halt_word);
		// Never-taken branches as fill, so each word names its own address
		for (int i = 0; i < 512; i++) begin
			imem[i] = branch_word(3'b000, i);
		end
		start = int'(reset_pc[9:1]);
		foreach (prog[k]) begin
			imem[start + k] = prog[k];
		end
	endfunction

	// ------------------------------
	// ISA reference model
	// ------------------------------

	function automatic void run_model();
		logic [15:0] r [8];
		logic [15:0] mem [logic [15:0]];
		logic [15:0] pc, ir, a, b, res, addr;
		logic [2:0] cc;
		int steps;
		for (int i = 0; i < 8; i++) begin
			r[i] = '0;
		end
		cc = 3'b010;
		pc = reset_pc;
		steps = 0;
		ir = imem[pc[9:1]];
		while (ir != halt_word && steps < 10000) begin
			pc = pc + 16'd2;
			a = r[ir[8:6]];
			b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
			addr = a + {{9{ir[5]}}, ir[5:0], 1'b0};
			res = '0;
			case (ir[15:12])
				4'b0001: res = a + b;
				4'b0101: res = a & b;
				4'b1001: res = ~a;
				4'b0110: res = mem.exists(addr) ? mem[addr] : fill_word(addr);
				4'b0111: begin
					mem[addr] = r[ir[11:9]];
					exp_addr.push_back(addr);
					exp_data.push_back(r[ir[11:9]]);
				end
				4'b0000: begin
					if (|(ir[11:9] & cc)) begin
						pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
					end
				end
				default: ;
			endcase
			if (ir[15:12] inside {4'b0001, 4'b0101, 4'b1001, 4'b0110}) begin
				r[ir[11:9]] = res;
				cc = res[15] ? 3'b100 : (res == '0 ? 3'b010 : 3'b001);
			end
			ir = imem[pc[9:1]];
			steps++;
		end
		if (steps >= 10000) begin
			errors++;
			$display("reference model never reached the end of the program");
		end
	endfunction

	// ------------------------------
	// Memory responders
	// ------------------------------

	always @(posedge clk) begin
		#1;
		resp_a = 1'b0;
		resp_b = 1'b0;
		if (mem_read1 === 1'b1) begin
			if (!a_busy) begin
				a_busy = 1'b1;
				a_wait = pick(4);
			end
			if (a_wait == 0) begin
				resp_a = 1'b1;
				mem_rdata1 = imem[mem_addr1[9:1]];
				a_busy = 1'b0;
			end else begin
				a_wait--;
			end
		end
		if (mem_read2 === 1'b1 || mem_write2 === 1'b1) begin
			if (!b_busy) begin
				b_busy = 1'b1;
				b_wait = pick(4);
			end
			if (b_wait == 0) begin
				resp_b = 1'b1;
				b_busy = 1'b0;
				if (mem_write2) begin
					dmem[mem_addr2] = mem_wdata2;
				end else begin
					mem_rdata2 = dmem.exists(mem_addr2) ? dmem[mem_addr2] : fill_word(mem_addr2);
				end
			end else begin
				b_wait--;
			end
		end
	end

	// Store checker
	always @(negedge clk) begin
		if (rst_n === 1'b1 && mem_write2 === 1'b1 && resp_b === 1'b1) begin
			if (stores_seen >= exp_addr.size()) begin
				errors++;
				$display("%0t: store to %h that the program should not make", $time, mem_addr2);
			end else begin
				if (mem_addr2 !== exp_addr[stores_seen]) begin
					errors++;
					$display("[ERROR] %0t mem_addr2 got %h expected %h", $time, mem_addr2,
						exp_addr[stores_seen]);
				end
				if (mem_wdata2 !== exp_data[stores_seen]) begin
					errors++;
					$display("[ERROR] %0t mem_wdata2 got %h expected %h", $time, mem_wdata2,
						exp_data[stores_seen]);
				end
				if (mem_byte_enable2 !== 2'b11) begin
					errors++;
					$display("[ERROR] %0t mem_byte_enable2 got %b expected 11", $time,
						mem_byte_enable2);
				end
			end
			stores_seen++;
		end
	end

	initial begin
		int cycles;
		mem_rdata1 = '0;
		mem_rdata2 = '0;
		resp_a = 1'b0;
		resp_b = 1'b0;
		a_busy = 1'b0;
		b_busy = 1'b0;
		a_wait = 0;
		b_wait = 0;
		build_program();
		run_model();

		// First cycle after reset release, before any fetch response can be taken
		cycles = 0;
		while (rst_n !== 1'b1 && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (rst_n !== 1'b1) begin
			$display("reset was never released");
			$display("sim failed");
			$finish;
		end
		if (mem_read1 !== 1'b1 || mem_addr1 !== reset_pc) begin
			errors++;
			$display("[ERROR] %0t mem_addr1 got %h expected %h with read %b", $time, mem_addr1,
				reset_pc, mem_read1);
		end
		repeat (8) begin
			if (mem_read2 !== 1'b0 || mem_write2 !== 1'b0) begin
				errors++;
				$display("%0t: data port active before any memory instruction", $time);
			end
			@(negedge clk);
		end

		cycles = 0;
		while (stores_seen < exp_addr.size() && cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		if (stores_seen < exp_addr.size()) begin
			$display("timeout after %0d cycles with %0d of %0d stores seen", cycles,
				stores_seen, exp_addr.size());
			$display("sim failed");
			$finish;
		end
		// Drain so that stray stores past the end get caught
		repeat (40) @(posedge clk);

		$display("errors %0d, stores seen %0d, stores expected %0d", errors, stores_seen,
			exp_addr.size());
		if (errors == 0 && stores_seen == exp_addr.size()) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule : tb_cpu

`default_nettype wire
